// ==== exu_pkg.sv ====
package exu_pkg;

  // datapath and tag widths
  localparam int unsigned XLEN  = 64;
  localparam int unsigned TAG_W = 4;

  // opcode numbers are fixed, the test data refers to them
  typedef enum logic [4:0] {
    OP_ADD    = 5'd0,
    OP_SUB    = 5'd1,
    OP_SLL    = 5'd2,
    OP_SLT    = 5'd3,
    OP_SLTU   = 5'd4,
    OP_SRL    = 5'd5,
    OP_SRA    = 5'd6,
    OP_XOR    = 5'd7,
    OP_OR     = 5'd8,
    OP_AND    = 5'd9,
    OP_PASS2  = 5'd10,
    // 32-bit word variants, sign-extended result
    OP_ADDW   = 5'd11,
    OP_SUBW   = 5'd12,
    OP_SLLW   = 5'd13,
    OP_SRLW   = 5'd14,
    OP_SRAW   = 5'd15,
    // multiplier
    OP_MUL    = 5'd16,
    OP_MULH   = 5'd17,
    OP_MULHSU = 5'd18,
    OP_MULHU  = 5'd19,
    // divider
    OP_DIV    = 5'd20,
    OP_DIVU   = 5'd21,
    OP_REM    = 5'd22,
    OP_REMU   = 5'd23
  } exu_op_e;

  typedef enum logic [1:0] {UNIT_ALU, UNIT_MUL, UNIT_DIV} exu_unit_e;

  typedef struct packed {
    logic [TAG_W-1:0] tag;
    exu_op_e          op;
    logic [XLEN-1:0]  src1;
    logic [XLEN-1:0]  src2;
  } exu_issue_t;

  typedef struct packed {
    logic [TAG_W-1:0] tag;
    logic [XLEN-1:0]  data;
  } exu_result_t;

  // which unit executes an opcode
  function automatic exu_unit_e unit_of_op(exu_op_e op);
    case (op)
      OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU: return UNIT_MUL;
      OP_DIV, OP_DIVU, OP_REM, OP_REMU:     return UNIT_DIV;
      default:                              return UNIT_ALU;
    endcase
  endfunction

endpackage

// ==== exu_alu.sv ====
module exu_alu import exu_pkg::*; #(
  parameter int unsigned XLEN = 64
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        start_i,
  input  exu_issue_t  issue_i,
  input  logic        grant_i,
  output logic        done_o,
  output exu_result_t result_o,
  output logic        busy_o
);

  localparam int unsigned SH_W = $clog2(XLEN);

  logic            sub;
  logic            word;
  logic            right;
  logic            arith;
  logic            carry;
  logic            ovf;
  logic            less_s;
  logic            less_u;
  logic            sign;
  logic [SH_W-1:0] shamt;
  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] addend;
  logic [XLEN-1:0] sum;
  logic [XLEN-1:0] rev_a;
  logic [XLEN-1:0] shr_src;
  logic [XLEN-1:0] shr;
  logic [XLEN-1:0] rev_shr;
  logic [XLEN-1:0] fill;
  logic [XLEN-1:0] shr_res;
  logic [XLEN-1:0] res;
  logic [XLEN-1:0] alu_res;
  logic            done_q;
  exu_result_t     res_q;

  always_comb begin
    op_a  = issue_i.src1;
    op_b  = issue_i.src2;
    sub   = issue_i.op inside {OP_SUB, OP_SUBW, OP_SLT, OP_SLTU};
    word  = issue_i.op inside {OP_ADDW, OP_SUBW, OP_SLLW, OP_SRLW, OP_SRAW};
    right = issue_i.op inside {OP_SRL, OP_SRA, OP_SRLW, OP_SRAW};
    arith = issue_i.op inside {OP_SRA, OP_SRAW};

    // one adder, subtract by inverting src2 and carrying in
    addend         = op_b ^ {XLEN{sub}};
    {carry, sum}   = {1'b0, op_a} + {1'b0, addend} + (XLEN+1)'(sub);
    ovf            = (op_a[XLEN-1] == addend[XLEN-1]) && (sum[XLEN-1] != op_a[XLEN-1]);
    less_s         = sum[XLEN-1] ^ ovf;
    // no carry out of a - b means a < b unsigned
    less_u         = ~carry;

    // left shifts run through the right shifter on the reversed operand
    for (int i = 0; i < XLEN; i++) begin
      rev_a[i] = op_a[XLEN-1-i];
    end
    shamt   = word ? SH_W'(op_b[4:0]) : op_b[SH_W-1:0];
    shr_src = !right ? rev_a :
              word   ? {{(XLEN-32){1'b0}}, op_a[31:0]} : op_a;
    shr     = shr_src >> shamt;
    for (int i = 0; i < XLEN; i++) begin
      rev_shr[i] = shr[XLEN-1-i];
    end

    // bits vacated by a right shift, within the word for the w forms
    fill    = word ? {{(XLEN-32){1'b0}}, ~(32'hffff_ffff >> shamt[4:0])}
                   : ~({XLEN{1'b1}} >> shamt);
    sign    = word ? op_a[31] : op_a[XLEN-1];
    shr_res = shr | (fill & {XLEN{arith & sign}});

    case (issue_i.op)
      OP_ADD, OP_SUB, OP_ADDW, OP_SUBW: res = sum;
      OP_SLL, OP_SLLW:                  res = rev_shr;
      OP_SRL, OP_SRA, OP_SRLW, OP_SRAW: res = shr_res;
      OP_SLT:                           res = XLEN'(less_s);
      OP_SLTU:                          res = XLEN'(less_u);
      OP_XOR:                           res = op_a ^ op_b;
      OP_OR:                            res = op_a | op_b;
      OP_AND:                           res = op_a & op_b;
      OP_PASS2:                         res = op_b;
      default:                          res = '0;
    endcase

    alu_res = word ? {{(XLEN-32){res[31]}}, res[31:0]} : res;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done_q <= 1'b0;
    end else if (start_i) begin
      done_q <= 1'b1;
    end else if (grant_i) begin
      done_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (start_i) begin
      res_q <= '{tag: issue_i.tag, data: alu_res};
    end
  end

  assign done_o   = done_q;
  assign result_o = res_q;
  // the arbiter grants the alu in the same cycle, so this stays low in practice
  assign busy_o   = done_q & ~grant_i;

endmodule

// ==== exu_mul.sv ====
module exu_mul import exu_pkg::*; #(
  parameter int unsigned XLEN = 64
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        start_i,
  input  exu_issue_t  issue_i,
  input  logic        grant_i,
  output logic        done_o,
  output exu_result_t result_o,
  output logic        busy_o
);

  typedef enum logic [1:0] {IDLE, RUN, FIX, DONE} mul_state_e;

  localparam int unsigned CNT_W = $clog2(XLEN);

  mul_state_e         state_q;
  logic [CNT_W-1:0]   cnt_q;
  logic [2*XLEN-1:0]  prod_q;
  logic [XLEN-1:0]    mcand_q;
  logic               neg_q;
  logic               hi_q;
  logic [TAG_W-1:0]   tag_q;
  logic               s1_neg;
  logic               s2_neg;
  logic [XLEN-1:0]    mag1;
  logic [XLEN-1:0]    mag2;
  logic [XLEN:0]      step_sum;

  // operand signs, mulh signed by signed, mulhsu signed by unsigned
  always_comb begin
    s1_neg = (issue_i.op inside {OP_MULH, OP_MULHSU}) & issue_i.src1[XLEN-1];
    s2_neg = (issue_i.op == OP_MULH) & issue_i.src2[XLEN-1];
    mag1   = s1_neg ? -issue_i.src1 : issue_i.src1;
    mag2   = s2_neg ? -issue_i.src2 : issue_i.src2;
  end

  // add multiplicand into upper half when the current multiplier bit is set
  assign step_sum = {1'b0, prod_q[2*XLEN-1:XLEN]} + ({(XLEN+1){prod_q[0]}} & {1'b0, mcand_q});

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else if (start_i) begin
      state_q <= RUN;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        RUN: begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == CNT_W'(XLEN-1)) begin
            state_q <= FIX;
          end
        end
        FIX: state_q <= DONE;
        DONE: begin
          if (grant_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start_i) begin
      prod_q  <= {{XLEN{1'b0}}, mag2};
      mcand_q <= mag1;
      neg_q   <= s1_neg ^ s2_neg;
      hi_q    <= issue_i.op != OP_MUL;
      tag_q   <= issue_i.tag;
    end else if (state_q == RUN) begin
      prod_q <= {step_sum, prod_q[XLEN-1:1]};
    end else if (state_q == FIX && neg_q) begin
      prod_q <= -prod_q;
    end
  end

  assign done_o        = state_q == DONE;
  assign busy_o        = (state_q != IDLE) & ~grant_i;
  assign result_o.tag  = tag_q;
  assign result_o.data = hi_q ? prod_q[2*XLEN-1:XLEN] : prod_q[XLEN-1:0];

endmodule

// ==== exu_div.sv ====
module exu_div import exu_pkg::*; #(
  parameter int unsigned XLEN = 64
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        start_i,
  input  exu_issue_t  issue_i,
  input  logic        grant_i,
  output logic        done_o,
  output exu_result_t result_o,
  output logic        busy_o
);

  typedef enum logic [1:0] {IDLE, RUN, FIX, DONE} div_state_e;

  localparam int unsigned CNT_W = $clog2(XLEN);

  div_state_e        state_q;
  logic [CNT_W-1:0]  cnt_q;
  logic [XLEN-1:0]   quot_q;
  logic [XLEN-1:0]   rem_q;
  logic [XLEN-1:0]   dvsr_q;
  logic              q_neg_q;
  logic              r_neg_q;
  logic              rem_sel_q;
  logic [TAG_W-1:0]  tag_q;
  logic              is_signed;
  logic              div_zero;
  logic              div_ovf;
  logic              special;
  logic              s1_neg;
  logic              s2_neg;
  logic [XLEN-1:0]   mag1;
  logic [XLEN-1:0]   mag2;
  logic [XLEN:0]     shifted;
  logic [XLEN:0]     trial;

  always_comb begin
    is_signed = issue_i.op inside {OP_DIV, OP_REM};
    s1_neg    = is_signed & issue_i.src1[XLEN-1];
    s2_neg    = is_signed & issue_i.src2[XLEN-1];
    mag1      = s1_neg ? -issue_i.src1 : issue_i.src1;
    mag2      = s2_neg ? -issue_i.src2 : issue_i.src2;
    div_zero  = issue_i.src2 == '0;
    // most negative divided by minus one
    div_ovf   = is_signed && issue_i.src1 == {1'b1, {(XLEN-1){1'b0}}} &&
                issue_i.src2 == '1;
    special   = div_zero | div_ovf;
  end

  // one restoring step, next dividend bit shifted into the partial remainder
  assign shifted = {rem_q, quot_q[XLEN-1]};
  assign trial   = shifted - {1'b0, dvsr_q};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else if (start_i) begin
      state_q <= special ? DONE : RUN;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        RUN: begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == CNT_W'(XLEN-1)) begin
            state_q <= FIX;
          end
        end
        FIX: state_q <= DONE;
        DONE: begin
          if (grant_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start_i) begin
      tag_q     <= issue_i.tag;
      rem_sel_q <= issue_i.op inside {OP_REM, OP_REMU};
      q_neg_q   <= s1_neg ^ s2_neg;
      // remainder follows the dividend sign
      r_neg_q   <= s1_neg;
      dvsr_q    <= mag2;
      if (div_zero) begin
        quot_q <= '1;
        rem_q  <= issue_i.src1;
      end else if (div_ovf) begin
        quot_q <= issue_i.src1;
        rem_q  <= '0;
      end else begin
        quot_q <= mag1;
        rem_q  <= '0;
      end
    end else if (state_q == RUN) begin
      if (!trial[XLEN]) begin
        rem_q  <= trial[XLEN-1:0];
        quot_q <= {quot_q[XLEN-2:0], 1'b1};
      end else begin
        rem_q  <= shifted[XLEN-1:0];
        quot_q <= {quot_q[XLEN-2:0], 1'b0};
      end
    end else if (state_q == FIX) begin
      quot_q <= q_neg_q ? -quot_q : quot_q;
      rem_q  <= r_neg_q ? -rem_q : rem_q;
    end
  end

  assign done_o        = state_q == DONE;
  assign busy_o        = (state_q != IDLE) & ~grant_i;
  assign result_o.tag  = tag_q;
  assign result_o.data = rem_sel_q ? rem_q : quot_q;

endmodule

// ==== exu_result_arb.sv ====
module exu_result_arb import exu_pkg::*; #(
  parameter int unsigned XLEN  = 64,
  parameter int unsigned TAG_W = 4
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        alu_done_i,
  input  exu_result_t alu_res_i,
  input  logic        mul_done_i,
  input  exu_result_t mul_res_i,
  input  logic        div_done_i,
  input  exu_result_t div_res_i,
  output logic        alu_grant_o,
  output logic        mul_grant_o,
  output logic        div_grant_o,
  output logic        result_valid_o,
  output exu_result_t result_o
);

  localparam int unsigned RES_W = TAG_W + XLEN;

  logic mul_last_q;
  logic div_last_q;
  logic mul_req;
  logic div_req;

  // alu can return on consecutive cycles, only mul and div are held off
  // for the cycle in which they drop done
  assign mul_req = mul_done_i & ~mul_last_q;
  assign div_req = div_done_i & ~div_last_q;

  assign alu_grant_o = alu_done_i;
  assign mul_grant_o = mul_req & ~alu_done_i;
  assign div_grant_o = div_req & ~alu_done_i & ~mul_req;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mul_last_q <= 1'b0;
      div_last_q <= 1'b0;
    end else begin
      mul_last_q <= mul_grant_o;
      div_last_q <= div_grant_o;
    end
  end

  // grants are one-hot, so an and-or mux is enough
  assign result_valid_o = alu_grant_o | mul_grant_o | div_grant_o;
  assign result_o = ({RES_W{alu_grant_o}} & alu_res_i) |
                    ({RES_W{mul_grant_o}} & mul_res_i) |
                    ({RES_W{div_grant_o}} & div_res_i);

endmodule

// ==== exu_top.sv ====
module exu_top import exu_pkg::*; #(
  parameter int unsigned XLEN  = 64,
  parameter int unsigned TAG_W = 4
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        issue_valid_i,
  input  exu_issue_t  issue_i,
  output logic        result_valid_o,
  output exu_result_t result_o,
  output logic        alu_busy_o,
  output logic        mul_busy_o,
  output logic        div_busy_o
);

  exu_unit_e   unit;
  logic        alu_start;
  logic        mul_start;
  logic        div_start;
  logic        alu_done;
  logic        mul_done;
  logic        div_done;
  logic        alu_grant;
  logic        mul_grant;
  logic        div_grant;
  exu_result_t alu_res;
  exu_result_t mul_res;
  exu_result_t div_res;

  // steer the strobe to exactly one unit
  assign unit      = unit_of_op(issue_i.op);
  assign alu_start = issue_valid_i && unit == UNIT_ALU;
  assign mul_start = issue_valid_i && unit == UNIT_MUL;
  assign div_start = issue_valid_i && unit == UNIT_DIV;

  exu_alu #(.XLEN(XLEN)) i_alu (
    .clk, .rst_n, .start_i(alu_start), .issue_i, .grant_i(alu_grant),
    .done_o(alu_done), .result_o(alu_res), .busy_o(alu_busy_o)
  );

  exu_mul #(.XLEN(XLEN)) i_mul (
    .clk, .rst_n, .start_i(mul_start), .issue_i, .grant_i(mul_grant),
    .done_o(mul_done), .result_o(mul_res), .busy_o(mul_busy_o)
  );

  exu_div #(.XLEN(XLEN)) i_div (
    .clk, .rst_n, .start_i(div_start), .issue_i, .grant_i(div_grant),
    .done_o(div_done), .result_o(div_res), .busy_o(div_busy_o)
  );

  exu_result_arb #(.XLEN(XLEN), .TAG_W(TAG_W)) i_arb (
    .clk, .rst_n,
    .alu_done_i(alu_done), .alu_res_i(alu_res),
    .mul_done_i(mul_done), .mul_res_i(mul_res),
    .div_done_i(div_done), .div_res_i(div_res),
    .alu_grant_o(alu_grant), .mul_grant_o(mul_grant), .div_grant_o(div_grant),
    .result_valid_o, .result_o
  );

endmodule

// ==== tb_clkgen.sv ====
module tb_clkgen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // reset held low over the first 4 rising edges
  initial begin
    rst_n_o = 1'b0;
    repeat (4) @(posedge clk_o);
    #1 rst_n_o = 1'b1;
  end

endmodule

// ==== tb_checker.sv ====
module tb_checker import exu_pkg::*; #(
  parameter int unsigned MAX_TESTS = 64
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                issue_valid_i,
  input  exu_issue_t          issue_i,
  input  logic                result_valid_i,
  input  exu_result_t         result_i,
  input  logic                alu_busy_i,
  input  logic                mul_busy_i,
  input  logic                div_busy_i,
  output int                  pass_cnt_o,
  output int                  fail_cnt_o,
  output int                  returned_o,
  output logic [2**TAG_W-1:0] pending_o
);

  logic [XLEN-1:0] exp_data [MAX_TESTS];
  int              n_loaded;
  int              issued;
  int              cycle;
  // test index, issue cycle and executing unit per tag
  int              pend_idx   [2**TAG_W];
  int              pend_cycle [2**TAG_W];
  exu_unit_e       pend_unit  [2**TAG_W];

  task automatic load_expected();
    int               fd;
    int               n;
    logic [8*128-1:0] skip;
    logic [TAG_W-1:0] t;
    logic [4:0]       op;
    logic [XLEN-1:0]  a;
    logic [XLEN-1:0]  b;
    logic [XLEN-1:0]  e;
    n_loaded = 0;
    fd = $fopen("exu_input.txt", "r");
    if (fd == 0) begin
      $display("checker could not open exu_input.txt");
      return;
    end
    while (!$feof(fd)) begin
      n = $fscanf(fd, "%h %h %h %h %h\n", t, op, a, b, e);
      if (n == 5 && n_loaded < MAX_TESTS) begin
        exp_data[n_loaded] = e;
        n_loaded++;
      end else if (n != 5) begin
        // comment line
        if ($fgets(skip, fd) == 0) begin
          break;
        end
      end
    end
    $fclose(fd);
  endtask

  // a unit stays busy while it holds an operation from an earlier cycle
  // that is not returned in this one
  task automatic check_busy();
    logic [2:0] exp_busy;
    logic [2:0] act_busy;
    exp_busy = '0;
    for (int t = 0; t < 2**TAG_W; t++) begin
      if (pending_o[t] && !(result_valid_i && result_i.tag == t)) begin
        exp_busy[pend_unit[t]] = 1'b1;
      end
    end
    act_busy = {div_busy_i, mul_busy_i, alu_busy_i};
    if (act_busy !== exp_busy) begin
      $display("mismatch at %0t: busy flags div mul alu expected %b, got %b",
               $time, exp_busy, act_busy);
      fail_cnt_o++;
    end
  endtask

  task automatic check_result();
    logic [TAG_W-1:0] t;
    int               idx;
    t = result_i.tag;
    if (!pending_o[t]) begin
      $display("result for tag %h arrived with no operation of that tag in flight", t);
      fail_cnt_o++;
      return;
    end
    idx          = pend_idx[t];
    pending_o[t] = 1'b0;
    returned_o++;
    if (pend_unit[t] == UNIT_ALU && cycle - pend_cycle[t] != 1) begin
      $display("alu result for tag %h took %0d cycles instead of 1", t, cycle - pend_cycle[t]);
      fail_cnt_o++;
    end else if (result_i.data !== exp_data[idx]) begin
      $display("mismatch at %0t: tag %h, expected %h, got %h",
               $time, t, exp_data[idx], result_i.data);
      fail_cnt_o++;
    end else begin
      $display("tag %h test %0d ok, %h", t, idx, result_i.data);
      pass_cnt_o++;
    end
  endtask

  task automatic note_issue();
    logic [TAG_W-1:0] t;
    t = issue_i.tag;
    if (pending_o[t]) begin
      $display("tag %h issued again while still in flight", t);
      fail_cnt_o++;
    end
    if (issued >= n_loaded) begin
      $display("more operations issued than tests in exu_input.txt");
      fail_cnt_o++;
      return;
    end
    pend_idx[t]   = issued;
    pend_cycle[t] = cycle;
    pend_unit[t]  = unit_of_op(issue_i.op);
    pending_o[t]  = 1'b1;
    issued++;
  endtask

  initial begin
    pass_cnt_o = 0;
    fail_cnt_o = 0;
    returned_o = 0;
    pending_o  = '0;
    issued     = 0;
    cycle      = 0;
    load_expected();
  end

  // sample mid-cycle away from the driving edge
  always @(negedge clk) begin
    if (rst_n) begin
      cycle++;
      check_busy();
      if (result_valid_i) begin
        check_result();
      end
      if (issue_valid_i) begin
        note_issue();
      end
    end
  end

endmodule

// ==== tb_exu.sv ====
module tb_exu import exu_pkg::*; ();

  localparam int MAX_TESTS = 64;

  logic                clk;
  logic                rst_n;
  logic                issue_valid;
  exu_issue_t          issue;
  logic                result_valid;
  exu_result_t         result;
  logic                alu_busy;
  logic                mul_busy;
  logic                div_busy;
  int                  pass_cnt;
  int                  fail_cnt;
  int                  returned;
  logic [2**TAG_W-1:0] pending;

  logic [TAG_W-1:0]    tags  [MAX_TESTS];
  logic [4:0]          ops   [MAX_TESTS];
  logic [XLEN-1:0]     src1s [MAX_TESTS];
  logic [XLEN-1:0]     src2s [MAX_TESTS];
  int                  n_tests = 0;
  int                  issued  = 0;
  int                  cycles  = 0;
  int                  limit   = 0;

  tb_clkgen i_clkgen (.clk_o(clk), .rst_n_o(rst_n));

  exu_top #(.XLEN(XLEN), .TAG_W(TAG_W)) i_dut (
    .clk, .rst_n, .issue_valid_i(issue_valid), .issue_i(issue),
    .result_valid_o(result_valid), .result_o(result),
    .alu_busy_o(alu_busy), .mul_busy_o(mul_busy), .div_busy_o(div_busy)
  );

  tb_checker #(.MAX_TESTS(MAX_TESTS)) i_chk (
    .clk, .rst_n, .issue_valid_i(issue_valid), .issue_i(issue),
    .result_valid_i(result_valid), .result_i(result),
    .alu_busy_i(alu_busy), .mul_busy_i(mul_busy), .div_busy_i(div_busy),
    .pass_cnt_o(pass_cnt), .fail_cnt_o(fail_cnt), .returned_o(returned),
    .pending_o(pending)
  );

  task automatic load_tests();
    int               fd;
    int               n;
    logic [8*128-1:0] skip;
    logic [TAG_W-1:0] t;
    logic [4:0]       op;
    logic [XLEN-1:0]  a;
    logic [XLEN-1:0]  b;
    logic [XLEN-1:0]  e;
    fd = $fopen("exu_input.txt", "r");
    if (fd == 0) begin
      $display("could not open exu_input.txt");
      return;
    end
    while (!$feof(fd)) begin
      n = $fscanf(fd, "%h %h %h %h %h\n", t, op, a, b, e);
      if (n == 5 && n_tests < MAX_TESTS) begin
        tags[n_tests]  = t;
        ops[n_tests]   = op;
        src1s[n_tests] = a;
        src2s[n_tests] = b;
        n_tests++;
      end else if (n != 5) begin
        if ($fgets(skip, fd) == 0) begin
          break;
        end
      end
    end
    $fclose(fd);
  endtask

  function automatic logic target_busy(logic [4:0] op);
    case (unit_of_op(exu_op_e'(op)))
      UNIT_MUL: return mul_busy;
      UNIT_DIV: return div_busy;
      default:  return alu_busy;
    endcase
  endfunction

  task automatic print_counts();
    $display("tests: %0d passed, %0d failed, %0d of %0d returned",
             pass_cnt, fail_cnt, returned, n_tests);
  endtask

  initial begin
    int gap;
    issue_valid = 1'b0;
    issue       = '0;
    gap         = $urandom(32'h2690_e1a5);
    load_tests();
    if (n_tests == 0) begin
      $display("no tests loaded from exu_input.txt");
      $display("sim failed");
      $finish;
    end else begin
      limit = 80 * n_tests + 200;
      @(posedge rst_n);
      @(posedge clk);
      #1;
      for (int i = 0; i < n_tests; i++) begin
        gap = $urandom % 4;
        repeat (gap) begin
          @(posedge clk);
          #1;
        end
        // the target unit must be free before its strobe
        while (target_busy(ops[i])) begin
          @(posedge clk);
          #1;
        end
        issue_valid = 1'b1;
        issue.tag   = tags[i];
        issue.op    = exu_op_e'(ops[i]);
        issue.src1  = src1s[i];
        issue.src2  = src2s[i];
        issued++;
        @(posedge clk);
        #1;
        issue_valid = 1'b0;
      end
      wait (returned == n_tests);
      // a few spare cycles to catch stray results
      repeat (4) @(posedge clk);
      print_counts();
      if (fail_cnt == 0 && pass_cnt == n_tests) begin
        $display("sim passed");
      end else begin
        $display("sim failed");
      end
      $finish;
    end
  end

  always @(posedge clk) begin
    if (rst_n) begin
      cycles++;
    end
    if (limit != 0 && cycles >= limit) begin
      $display("timeout after %0d cycles, %0d of %0d tests issued", cycles, issued, n_tests);
      for (int t = 0; t < 2**TAG_W; t++) begin
        if (pending[t]) begin
          $display("tag %h never returned", t);
        end
      end
      print_counts();
      $display("sim failed");
      $finish;
    end
  end

endmodule

// ==== exu_input.txt ====
# tag op src1 src2 expected, all hex
# op numbers follow exu_op_e in exu_pkg.sv
0 00 7fffffffffffffff 0000000000000001 8000000000000000
1 00 ffffffffffffffff 0000000000000002 0000000000000001
2 01 0000000000000000 0000000000000001 ffffffffffffffff
3 03 ffffffffffffffff 0000000000000001 0000000000000001
4 04 ffffffffffffffff 0000000000000001 0000000000000000
5 03 8000000000000000 7fffffffffffffff 0000000000000001
6 0a 0000000000001234 0123456789abcdef 0123456789abcdef
7 07 f0f0f0f0f0f0f0f0 ff00ff00ff00ff00 0ff00ff00ff00ff0
8 08 f0f0f0f0f0f0f0f0 0f0f00000000000f fffff0f0f0f0f0ff
9 09 f0f0f0f0f0f0f0f0 ff00ff00ff00ff00 f000f000f000f000
a 02 0123456789abcdef 0000000000000000 0123456789abcdef
b 02 0000000000000001 000000000000003f 8000000000000000
c 05 8000000000000000 000000000000003f 0000000000000001
d 06 8000000000000000 0000000000000001 c000000000000000
e 06 8000000000000000 000000000000003f ffffffffffffffff
f 0b 000000007fffffff 0000000000000001 ffffffff80000000
0 0c ffffffff00000000 0000000000000001 ffffffffffffffff
1 0d 00000000c0000001 0000000000000021 ffffffff80000002
2 0e ffffffff80000000 0000000000000004 0000000008000000
3 0f 0000000080000000 0000000000000004 fffffffff8000000
4 10 8000000000000000 ffffffffffffffff 8000000000000000
5 11 8000000000000000 ffffffffffffffff 0000000000000000
6 12 ffffffffffffffff ffffffffffffffff ffffffffffffffff
7 13 ffffffffffffffff ffffffffffffffff fffffffffffffffe
8 10 ffffffffffffffff 0000000000000005 fffffffffffffffb
9 14 fffffffffffffff9 0000000000000002 fffffffffffffffd
a 16 fffffffffffffff9 0000000000000002 ffffffffffffffff
b 15 fffffffffffffff9 0000000000000002 7ffffffffffffffc
c 16 0000000000000007 fffffffffffffffe 0000000000000001
d 14 0000000000000064 0000000000000000 ffffffffffffffff
e 17 0000000000000064 0000000000000000 0000000000000064
f 14 8000000000000000 ffffffffffffffff 8000000000000000
0 16 8000000000000000 ffffffffffffffff 0000000000000000
1 10 0000000000000003 0000000000000007 0000000000000015
2 15 0000000000000064 0000000000000007 000000000000000e
3 00 0000000000000001 0000000000000002 0000000000000003
4 01 000000000000000a 0000000000000003 0000000000000007
5 07 00000000000000ff 000000000000000f 00000000000000f0
6 04 0000000000000000 0000000000000001 0000000000000001
7 0a 0000000000000000 000000000000005a 000000000000005a

// ==== src.f ====
exu_pkg.sv
exu_alu.sv
exu_mul.sv
exu_div.sv
exu_result_arb.sv
exu_top.sv
tb_clkgen.sv
tb_checker.sv
tb_exu.sv

// ==== Bender.yml ====
package:
  name: exu

sources:
  - files:
      - exu_pkg.sv
      - exu_alu.sv
      - exu_mul.sv
      - exu_div.sv
      - exu_result_arb.sv
      - exu_top.sv
  - target: test
    files:
      - tb_clkgen.sv
      - tb_checker.sv
      - tb_exu.sv
